// File: common/udp_hub_consts.svh
`ifndef UDP_HUB_CONSTS_SVH
`define UDP_HUB_CONSTS_SVH

// inbound packet path
`define UDP_NUM_LANES   6
`define UDP_PAYLOAD_W   64
`define UDP_KEEP_W      8

// service port table, lane 0 also catches 21616..21623
`define UDP_PORT_0      16'd21618
`define UDP_PORT_1      16'd21614
`define UDP_PORT_2      16'd21603
`define UDP_PORT_3      16'd21601
`define UDP_PORT_4      16'd21608
`define UDP_PORT_5      16'd37

// set bits are ignored in the compare
`define UDP_MASK_0      16'h0007
`define UDP_MASK_1      16'h0000
`define UDP_MASK_2      16'h0000
`define UDP_MASK_3      16'h0000
`define UDP_MASK_4      16'h0000
`define UDP_MASK_5      16'h0000

// transceiver register bank
`define GBE_NUM_LANES    2
`define GBE_DRP_SEL_BIT  13
`define GBE_LANE_SEL_BIT 2

`endif

// File: common/udp_stream_pkg.sv
`include "udp_hub_consts.svh"

package udp_stream_pkg;

    // header as delivered by the UDP core, destination port on top
    typedef struct packed {
        logic [15:0] dest_port;
        logic [15:0] src_port;
        logic [31:0] src_addr;
    } udp_hdr_t;

    // one payload beat
    typedef struct packed {
        logic [`UDP_PAYLOAD_W-1:0] data;
        logic [`UDP_KEEP_W-1:0]    keep;
        logic                      last;
    } udp_beat_t;

    // wide enough for all six lanes
    typedef logic [2:0] lane_idx_t;

    // framing state of the port switch
    typedef enum logic [1:0] {
        IDLE,
        PASS,
        DROP
    } sw_state_e;

endpackage

// File: common/gbe_ctrl_pkg.sv
`include "udp_hub_consts.svh"

package gbe_ctrl_pkg;

    // wishbone request into the register bank
    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`GBE_DRP_SEL_BIT:0] adr;
        logic [3:0]                sel;
        logic [31:0]               dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // forwarded request, window bit stripped
    typedef struct packed {
        logic                        cyc;
        logic                        stb;
        logic                        we;
        logic [`GBE_DRP_SEL_BIT-1:0] adr;
        logic [3:0]                  sel;
        logic [31:0]                 dat;
    } drp_req_t;

    typedef struct packed {
        logic        block_lock;
        logic        high_ber;
        logic [15:0] dmonitor;
    } lane_status_t;

    typedef struct packed {
        logic       eye_rst;
        logic [2:0] loopback;
    } lane_ctrl_t;

endpackage

// File: port_switch/udp_port_classifier.sv
`timescale 1ns/100ps
`include "udp_hub_consts.svh"

module udp_port_classifier
    import udp_stream_pkg::*;
(
    input  logic [15:0] dest_port_i,
    output logic        match_o,
    output lane_idx_t   lane_o
);

    localparam logic [15:0] PORT_TABLE [`UDP_NUM_LANES] = '{
        `UDP_PORT_0, `UDP_PORT_1, `UDP_PORT_2,
        `UDP_PORT_3, `UDP_PORT_4, `UDP_PORT_5
    };

    localparam logic [15:0] MASK_TABLE [`UDP_NUM_LANES] = '{
        `UDP_MASK_0, `UDP_MASK_1, `UDP_MASK_2,
        `UDP_MASK_3, `UDP_MASK_4, `UDP_MASK_5
    };

    logic [`UDP_NUM_LANES-1:0] hit;

    // compare every entry with its don't-care bits cleared
    always_comb begin
        for (int i = 0; i < `UDP_NUM_LANES; i++) begin
            hit[i] = ((dest_port_i ^ PORT_TABLE[i]) & ~MASK_TABLE[i]) == 16'd0;
        end
    end

    // walk down so the lowest hitting entry is the one left standing
    always_comb begin
        match_o = 1'b0;
        lane_o  = '0;
        for (int i = `UDP_NUM_LANES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                match_o = 1'b1;
                lane_o  = lane_idx_t'(i);
            end
        end
    end

endmodule

// File: port_switch/udp_port_switch.sv
`timescale 1ns/100ps
`include "udp_hub_consts.svh"

module udp_port_switch
    import udp_stream_pkg::*;
(
    input  logic                            wb_clk_i,
    input  logic                            rst_n_i,
    input  udp_hdr_t                        s_hdr_i,
    input  logic                            s_hdr_valid_i,
    output logic                            s_hdr_ready_o,
    input  udp_beat_t                       s_beat_i,
    input  logic                            s_beat_valid_i,
    output logic                            s_beat_ready_o,
    output udp_hdr_t  [`UDP_NUM_LANES-1:0]  m_hdr_o,
    output logic      [`UDP_NUM_LANES-1:0]  m_hdr_valid_o,
    input  logic      [`UDP_NUM_LANES-1:0]  m_hdr_ready_i,
    output udp_beat_t [`UDP_NUM_LANES-1:0]  m_beat_o,
    output logic      [`UDP_NUM_LANES-1:0]  m_beat_valid_o,
    input  logic      [`UDP_NUM_LANES-1:0]  m_beat_ready_i
);

    sw_state_e state_q;
    lane_idx_t lane_q;
    logic      cls_match;
    lane_idx_t cls_lane;
    logic      hdr_xfer;
    logic      beat_xfer;

    udp_port_classifier u_classifier (
        .dest_port_i (s_hdr_i.dest_port),
        .match_o     (cls_match),
        .lane_o      (cls_lane)
    );

    // payload fans out to every lane, only valid picks the receiver
    assign m_hdr_o  = {`UDP_NUM_LANES{s_hdr_i}};
    assign m_beat_o = {`UDP_NUM_LANES{s_beat_i}};

    always_comb begin
        m_hdr_valid_o  = '0;
        m_beat_valid_o = '0;
        s_hdr_ready_o  = 1'b0;
        s_beat_ready_o = 1'b0;
        case (state_q)
            IDLE: begin
                // unmatched headers are swallowed right away
                if (cls_match) begin
                    m_hdr_valid_o[cls_lane] = s_hdr_valid_i;
                    s_hdr_ready_o           = m_hdr_ready_i[cls_lane];
                end else begin
                    s_hdr_ready_o = 1'b1;
                end
            end
            PASS: begin
                m_beat_valid_o[lane_q] = s_beat_valid_i;
                s_beat_ready_o         = m_beat_ready_i[lane_q];
            end
            DROP: begin
                s_beat_ready_o = 1'b1;
            end
            default: begin
                s_hdr_ready_o = 1'b0;
            end
        endcase
    end

    assign hdr_xfer  = s_hdr_valid_i && s_hdr_ready_o;
    assign beat_xfer = s_beat_valid_i && s_beat_ready_o;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            lane_q  <= '0;
        end else begin
            if (state_q == IDLE && hdr_xfer) begin
                state_q <= cls_match ? PASS : DROP;
                lane_q  <= cls_lane;
            end else if (state_q != IDLE && beat_xfer && s_beat_i.last) begin
                state_q <= IDLE;
            end
        end
    end

    // one destination for the whole packet, header and beats alike
    a_one_lane: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        $onehot0(m_hdr_valid_o | m_beat_valid_o) && !(|m_hdr_valid_o && |m_beat_valid_o));

    a_no_beat_in_idle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        (state_q == IDLE) |-> (m_beat_valid_o == '0));

endmodule

// File: gbe_regs/gbe_lane_regs.sv
`timescale 1ns/100ps
`include "udp_hub_consts.svh"

module gbe_lane_regs
    import gbe_ctrl_pkg::*;
(
    input  logic                               wb_clk_i,
    input  logic                               rst_n_i,
    input  wb_req_t                            gtp_req_i,
    output wb_rsp_t                            gtp_rsp_o,
    output drp_req_t                           drp_req_o,
    input  wb_rsp_t                            drp_rsp_i,
    input  logic                               qpll_lock_i,
    input  lane_status_t [`GBE_NUM_LANES-1:0]  lane_status_i,
    output logic                               gbe_rst_o,
    output lane_ctrl_t   [`GBE_NUM_LANES-1:0]  lane_ctrl_o
);

    logic                              drp_sel;
    logic                              lane_sel;
    logic                              local_stb;
    logic                              gbe_rst_q;
    lane_ctrl_t [`GBE_NUM_LANES-1:0]   lane_ctrl_q;
    logic                              ack_q;
    logic [31:0]                       status_q;
    logic [31:0]                       status_word [`GBE_NUM_LANES];

    assign drp_sel   = gtp_req_i.adr[`GBE_DRP_SEL_BIT];
    assign lane_sel  = gtp_req_i.adr[`GBE_LANE_SEL_BIT];
    assign local_stb = gtp_req_i.cyc && gtp_req_i.stb && !drp_sel;

    // upper half of the space goes straight to the DRP bridge
    assign drp_req_o.cyc = gtp_req_i.cyc && drp_sel;
    assign drp_req_o.stb = drp_req_o.cyc;
    assign drp_req_o.we  = gtp_req_i.we;
    assign drp_req_o.adr = gtp_req_i.adr[`GBE_DRP_SEL_BIT-1:0];
    assign drp_req_o.sel = gtp_req_i.sel;
    assign drp_req_o.dat = gtp_req_i.dat;

    assign gtp_rsp_o.ack = drp_sel ? drp_rsp_i.ack : (ack_q && gtp_req_i.cyc);
    assign gtp_rsp_o.dat = drp_sel ? drp_rsp_i.dat : status_q;

    // per-lane status layout
    always_comb begin
        for (int i = 0; i < `GBE_NUM_LANES; i++) begin
            status_word[i] = {lane_status_i[i].dmonitor,
                              5'd0,
                              lane_ctrl_q[i].loopback,
                              3'd0,
                              lane_ctrl_q[i].eye_rst,
                              lane_status_i[i].high_ber,
                              lane_status_i[i].block_lock,
                              qpll_lock_i,
                              gbe_rst_q};
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            gbe_rst_q   <= 1'b0;
            lane_ctrl_q <= '0;
            ack_q       <= 1'b0;
            status_q    <= '0;
        end else begin
            ack_q <= local_stb;
            if (local_stb && gtp_req_i.we) begin
                if (gtp_req_i.sel[0]) begin
                    gbe_rst_q                   <= gtp_req_i.dat[0];
                    lane_ctrl_q[lane_sel].eye_rst <= gtp_req_i.dat[4];
                end
                if (gtp_req_i.sel[1]) begin
                    lane_ctrl_q[lane_sel].loopback <= gtp_req_i.dat[10:8];
                end
            end
            // snapshot taken in the strobe cycle, presented with the ack
            if (local_stb && !gtp_req_i.we) begin
                status_q <= status_word[lane_sel];
            end
        end
    end

    assign gbe_rst_o   = gbe_rst_q;
    assign lane_ctrl_o = lane_ctrl_q;

    a_local_ack: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        (!drp_sel && gtp_rsp_o.ack) |-> (gtp_req_i.cyc && $past(local_stb)));

    a_drp_window: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        drp_req_o.cyc |-> gtp_req_i.adr[`GBE_DRP_SEL_BIT]);

endmodule

// File: rtl/udp_hub_top.sv
`timescale 1ns/100ps
`include "udp_hub_consts.svh"

module udp_hub_top
    import udp_stream_pkg::*;
    import gbe_ctrl_pkg::*;
(
    input  logic                                 wb_clk_i,
    input  logic                                 rst_n_i,
    // inbound packet stream
    input  udp_hdr_t                             s_hdr_i,
    input  logic                                 s_hdr_valid_i,
    output logic                                 s_hdr_ready_o,
    input  udp_beat_t                            s_beat_i,
    input  logic                                 s_beat_valid_i,
    output logic                                 s_beat_ready_o,
    // per-service output lanes
    output udp_hdr_t  [`UDP_NUM_LANES-1:0]       m_hdr_o,
    output logic      [`UDP_NUM_LANES-1:0]       m_hdr_valid_o,
    input  logic      [`UDP_NUM_LANES-1:0]       m_hdr_ready_i,
    output udp_beat_t [`UDP_NUM_LANES-1:0]       m_beat_o,
    output logic      [`UDP_NUM_LANES-1:0]       m_beat_valid_o,
    input  logic      [`UDP_NUM_LANES-1:0]       m_beat_ready_i,
    // register bus and DRP window
    input  wb_req_t                              gtp_req_i,
    output wb_rsp_t                              gtp_rsp_o,
    output drp_req_t                             drp_req_o,
    input  wb_rsp_t                              drp_rsp_i,
    // PHY side
    input  logic                                 qpll_lock_i,
    input  lane_status_t [`GBE_NUM_LANES-1:0]    lane_status_i,
    output logic                                 gbe_rst_o,
    output lane_ctrl_t   [`GBE_NUM_LANES-1:0]    lane_ctrl_o
);

    udp_port_switch u_port_switch (
        .wb_clk_i       (wb_clk_i),
        .rst_n_i        (rst_n_i),
        .s_hdr_i        (s_hdr_i),
        .s_hdr_valid_i  (s_hdr_valid_i),
        .s_hdr_ready_o  (s_hdr_ready_o),
        .s_beat_i       (s_beat_i),
        .s_beat_valid_i (s_beat_valid_i),
        .s_beat_ready_o (s_beat_ready_o),
        .m_hdr_o        (m_hdr_o),
        .m_hdr_valid_o  (m_hdr_valid_o),
        .m_hdr_ready_i  (m_hdr_ready_i),
        .m_beat_o       (m_beat_o),
        .m_beat_valid_o (m_beat_valid_o),
        .m_beat_ready_i (m_beat_ready_i)
    );

    gbe_lane_regs u_lane_regs (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .gtp_req_i     (gtp_req_i),
        .gtp_rsp_o     (gtp_rsp_o),
        .drp_req_o     (drp_req_o),
        .drp_rsp_i     (drp_rsp_i),
        .qpll_lock_i   (qpll_lock_i),
        .lane_status_i (lane_status_i),
        .gbe_rst_o     (gbe_rst_o),
        .lane_ctrl_o   (lane_ctrl_o)
    );

endmodule

// File: verif/udp_hub_checker.sv
`timescale 1ns/100ps
`include "udp_hub_consts.svh"

module udp_hub_checker
    import udp_stream_pkg::*;
    import gbe_ctrl_pkg::*;
(
    input  logic                                 wb_clk_i,
    input  logic                                 rst_n_i,
    input  logic [8*16-1:0]                      test_name_i,
    input  udp_hdr_t                             s_hdr_i,
    input  logic                                 s_hdr_valid_i,
    input  logic                                 s_hdr_ready_i,
    input  udp_beat_t                            s_beat_i,
    input  logic                                 s_beat_valid_i,
    input  logic                                 s_beat_ready_i,
    input  udp_hdr_t  [`UDP_NUM_LANES-1:0]       m_hdr_i,
    input  logic      [`UDP_NUM_LANES-1:0]       m_hdr_valid_i,
    input  logic      [`UDP_NUM_LANES-1:0]       m_hdr_ready_i,
    input  udp_beat_t [`UDP_NUM_LANES-1:0]       m_beat_i,
    input  logic      [`UDP_NUM_LANES-1:0]       m_beat_valid_i,
    input  logic      [`UDP_NUM_LANES-1:0]       m_beat_ready_i,
    input  wb_req_t                              gtp_req_i,
    input  wb_rsp_t                              gtp_rsp_i,
    input  drp_req_t                             drp_req_i,
    input  wb_rsp_t                              drp_rsp_i,
    input  logic                                 qpll_lock_i,
    input  lane_status_t [`GBE_NUM_LANES-1:0]    lane_status_i,
    input  logic                                 gbe_rst_i,
    input  lane_ctrl_t   [`GBE_NUM_LANES-1:0]    lane_ctrl_i,
    output logic [31:0]                          error_count_o,
    output logic [31:0]                          pending_o,
    output logic                                 timeout_o
);

    // 18 packets of at most 8 cycles, the 8 stalled ones about twice as long,
    // 11 bus accesses of at most 4 cycles plus reset and tail, rounded up
    localparam int STIM_CYCLES = 300;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    udp_hdr_t  hdr_q  [`UDP_NUM_LANES][$];
    udp_beat_t beat_q [`UDP_NUM_LANES][$];
    logic        in_packet = 1'b0;
    logic        cur_match = 1'b0;
    logic [2:0]  cur_lane = 3'd0;
    logic        prev_local = 1'b0;
    logic        prev_we = 1'b0;
    logic [31:0] prev_status = 32'd0;
    logic        sh_gbe_rst = 1'b0;
    logic        sh_eye [`GBE_NUM_LANES] = '{default: 1'b0};
    logic [2:0]  sh_lb [`GBE_NUM_LANES] = '{default: 3'd0};
    int          cycles = 0;

    initial begin
        error_count_o = 32'd0;
        pending_o     = 32'd0;
        timeout_o     = 1'b0;
    end

    function automatic logic [15:0] entry_port(input int i);
        case (i)
            0: return `UDP_PORT_0;
            1: return `UDP_PORT_1;
            2: return `UDP_PORT_2;
            3: return `UDP_PORT_3;
            4: return `UDP_PORT_4;
            default: return `UDP_PORT_5;
        endcase
    endfunction

    function automatic logic [15:0] entry_mask(input int i);
        case (i)
            0: return `UDP_MASK_0;
            1: return `UDP_MASK_1;
            2: return `UDP_MASK_2;
            3: return `UDP_MASK_3;
            4: return `UDP_MASK_4;
            default: return `UDP_MASK_5;
        endcase
    endfunction

    // bit 3 is the match flag, bits 2:0 the lowest lane that matched
    function automatic logic [3:0] expected_lane(input logic [15:0] port);
        logic [3:0] res;
        res = 4'd0;
        for (int i = 0; i < `UDP_NUM_LANES; i++) begin
            if (!res[3] && ((port & ~entry_mask(i)) == (entry_port(i) & ~entry_mask(i)))) begin
                res = {1'b1, 3'(i)};
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] drp_pattern(input logic [12:0] adr);
        return {adr, ~adr, 6'b101101};
    endfunction

    function automatic logic [31:0] expected_status(input logic lane);
        logic [31:0] w;
        w        = 32'd0;
        w[0]     = sh_gbe_rst;
        w[1]     = qpll_lock_i;
        w[2]     = lane_status_i[lane].block_lock;
        w[3]     = lane_status_i[lane].high_ber;
        w[4]     = sh_eye[lane];
        w[10:8]  = sh_lb[lane];
        w[31:16] = lane_status_i[lane].dmonitor;
        return w;
    endfunction

    task automatic report_mismatch(input logic [72:0] exp, input logic [72:0] act);
        $display("MISMATCH %0s: expected %h actual %h", test_name_i, exp, act);
        error_count_o = error_count_o + 32'd1;
    endtask

    task automatic report_error(input string what);
        $display("ERROR %0s: %0s", test_name_i, what);
        error_count_o = error_count_o + 32'd1;
    endtask

    task automatic check_packet_path();
        logic [3:0] pred;
        udp_hdr_t   hdr;
        udp_beat_t  beat;
        int         total;
        // beat side uses the packet state from before this cycle's header
        if (in_packet) begin
            if (m_hdr_valid_i != '0)
                report_error("header valid raised inside a packet");
            if (cur_match) begin
                if (s_beat_ready_i !== m_beat_ready_i[cur_lane])
                    report_error("input beat ready does not follow the lane ready");
                if (m_beat_valid_i !== (6'(s_beat_valid_i) << cur_lane))
                    report_mismatch(73'(6'(s_beat_valid_i) << cur_lane), 73'(m_beat_valid_i));
            end
            if (!cur_match && (s_beat_ready_i !== 1'b1 || m_beat_valid_i != '0))
                report_error("dropped packet is not swallowed silently");
            if (s_beat_valid_i && s_beat_ready_i) begin
                if (cur_match)
                    beat_q[cur_lane].push_back(s_beat_i);
                if (s_beat_i.last)
                    in_packet = 1'b0;
            end
        end else begin
            if (s_beat_valid_i && s_beat_ready_i)
                report_error("beat accepted outside a packet");
            if (m_beat_valid_i != '0)
                report_error("beat valid raised outside a packet");
            if (!s_hdr_valid_i && m_hdr_valid_i != '0)
                report_error("header valid raised with no header offered");
        end
        if (!in_packet && s_hdr_valid_i) begin
            pred = expected_lane(s_hdr_i.dest_port);
            if (pred[3]) begin
                if (m_hdr_valid_i != (6'd1 << pred[2:0]))
                    report_mismatch(73'(6'd1 << pred[2:0]), 73'(m_hdr_valid_i));
                if (s_hdr_ready_i !== m_hdr_ready_i[pred[2:0]])
                    report_error("header ready does not follow the lane ready");
            end else if (m_hdr_valid_i != '0 || s_hdr_ready_i !== 1'b1) begin
                report_error("unmatched header was not dropped");
            end
            if (s_hdr_ready_i) begin
                in_packet = 1'b1;
                cur_match = pred[3];
                cur_lane  = pred[2:0];
                if (pred[3])
                    hdr_q[pred[2:0]].push_back(s_hdr_i);
            end
        end
        for (int i = 0; i < `UDP_NUM_LANES; i++) begin
            if (m_hdr_valid_i[i] && m_hdr_ready_i[i]) begin
                if (hdr_q[i].size() == 0) begin
                    report_error("unexpected header on an output lane");
                end else begin
                    hdr = hdr_q[i].pop_front();
                    if (m_hdr_i[i] !== hdr)
                        report_mismatch(73'(hdr), 73'(m_hdr_i[i]));
                end
            end
            if (m_beat_valid_i[i] && m_beat_ready_i[i]) begin
                if (beat_q[i].size() == 0) begin
                    report_error("unexpected beat on an output lane");
                end else begin
                    beat = beat_q[i].pop_front();
                    if (m_beat_i[i] !== beat)
                        report_mismatch(73'(beat), 73'(m_beat_i[i]));
                end
            end
        end
        total = 0;
        for (int i = 0; i < `UDP_NUM_LANES; i++)
            total = total + hdr_q[i].size() + beat_q[i].size();
        pending_o = 32'(total);
    endtask

    task automatic check_register_path();
        logic local_stb;
        logic lane;
        local_stb = gtp_req_i.cyc && gtp_req_i.stb && !gtp_req_i.adr[`GBE_DRP_SEL_BIT];
        lane      = gtp_req_i.adr[`GBE_LANE_SEL_BIT];
        if (gbe_rst_i !== sh_gbe_rst)
            report_mismatch(73'(sh_gbe_rst), 73'(gbe_rst_i));
        for (int i = 0; i < `GBE_NUM_LANES; i++) begin
            if (lane_ctrl_i[i] !== {sh_eye[i], sh_lb[i]})
                report_mismatch(73'({sh_eye[i], sh_lb[i]}), 73'(lane_ctrl_i[i]));
        end
        if (gtp_req_i.adr[`GBE_DRP_SEL_BIT]) begin
            if (drp_req_i.cyc !== gtp_req_i.cyc || drp_req_i.stb !== gtp_req_i.cyc)
                report_error("DRP strobe does not follow the bus cycle");
            if (gtp_req_i.cyc && drp_req_i.adr !== gtp_req_i.adr[`GBE_DRP_SEL_BIT-1:0])
                report_mismatch(73'(gtp_req_i.adr[12:0]), 73'(drp_req_i.adr));
            if (gtp_req_i.cyc && (drp_req_i.dat !== gtp_req_i.dat || drp_req_i.we !== gtp_req_i.we
                    || drp_req_i.sel !== gtp_req_i.sel))
                report_error("DRP request data, select or direction differs from the bus");
            if (gtp_rsp_i !== drp_rsp_i)
                report_mismatch(73'(drp_rsp_i), 73'(gtp_rsp_i));
            if (gtp_rsp_i.ack && gtp_rsp_i.dat !== drp_pattern(gtp_req_i.adr[12:0]))
                report_mismatch(73'(drp_pattern(gtp_req_i.adr[12:0])), 73'(gtp_rsp_i.dat));
        end else begin
            if (drp_req_i.cyc)
                report_error("DRP cycle raised for a local address");
            if (gtp_rsp_i.ack !== (prev_local && gtp_req_i.cyc))
                report_error("local ack not exactly one cycle after the strobe");
            if (gtp_rsp_i.ack && prev_local && !prev_we && gtp_rsp_i.dat !== prev_status)
                report_mismatch(73'(prev_status), 73'(gtp_rsp_i.dat));
        end
        if (local_stb)
            prev_status = expected_status(lane);
        // shadow takes the write now, the DUT shows it after the next edge
        if (local_stb && gtp_req_i.we) begin
            if (gtp_req_i.sel[0]) begin
                sh_gbe_rst   = gtp_req_i.dat[0];
                sh_eye[lane] = gtp_req_i.dat[4];
            end
            if (gtp_req_i.sel[1])
                sh_lb[lane] = gtp_req_i.dat[10:8];
        end
        prev_local = local_stb;
        prev_we    = gtp_req_i.we;
    endtask

    // everything is stable at the falling edge
    always @(negedge wb_clk_i) begin
        if (rst_n_i) begin
            check_packet_path();
            check_register_path();
        end
    end

    always @(posedge wb_clk_i) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            timeout_o = 1'b1;
    end

endmodule

// File: verif/tb_udp_hub.sv
`timescale 1ns/100ps
`include "udp_hub_consts.svh"

module tb_udp_hub
    import udp_stream_pkg::*;
    import gbe_ctrl_pkg::*;
;

    logic                                wb_clk_i;
    logic                                rst_n_i;
    udp_hdr_t                            s_hdr_i;
    logic                                s_hdr_valid_i;
    logic                                s_hdr_ready_o;
    udp_beat_t                           s_beat_i;
    logic                                s_beat_valid_i;
    logic                                s_beat_ready_o;
    udp_hdr_t  [`UDP_NUM_LANES-1:0]      m_hdr_o;
    logic      [`UDP_NUM_LANES-1:0]      m_hdr_valid_o;
    logic      [`UDP_NUM_LANES-1:0]      m_hdr_ready_i;
    udp_beat_t [`UDP_NUM_LANES-1:0]      m_beat_o;
    logic      [`UDP_NUM_LANES-1:0]      m_beat_valid_o;
    logic      [`UDP_NUM_LANES-1:0]      m_beat_ready_i;
    wb_req_t                             gtp_req_i;
    wb_rsp_t                             gtp_rsp_o;
    drp_req_t                            drp_req_o;
    wb_rsp_t                             drp_rsp_i;
    logic                                qpll_lock_i;
    lane_status_t [`GBE_NUM_LANES-1:0]   lane_status_i;
    logic                                gbe_rst_o;
    lane_ctrl_t   [`GBE_NUM_LANES-1:0]   lane_ctrl_o;

    logic [8*16-1:0] test_name;
    logic [31:0]     error_count;
    logic [31:0]     pending;
    logic            timeout;
    logic            stall_en;
    logic [1:0]      drp_wait;
    integer          seed = 6145;

    udp_hub_top i_dut (.*);

    udp_hub_checker i_chk (
        .wb_clk_i       (wb_clk_i),
        .rst_n_i        (rst_n_i),
        .test_name_i    (test_name),
        .s_hdr_i        (s_hdr_i),
        .s_hdr_valid_i  (s_hdr_valid_i),
        .s_hdr_ready_i  (s_hdr_ready_o),
        .s_beat_i       (s_beat_i),
        .s_beat_valid_i (s_beat_valid_i),
        .s_beat_ready_i (s_beat_ready_o),
        .m_hdr_i        (m_hdr_o),
        .m_hdr_valid_i  (m_hdr_valid_o),
        .m_hdr_ready_i  (m_hdr_ready_i),
        .m_beat_i       (m_beat_o),
        .m_beat_valid_i (m_beat_valid_o),
        .m_beat_ready_i (m_beat_ready_i),
        .gtp_req_i      (gtp_req_i),
        .gtp_rsp_i      (gtp_rsp_o),
        .drp_req_i      (drp_req_o),
        .drp_rsp_i      (drp_rsp_i),
        .qpll_lock_i    (qpll_lock_i),
        .lane_status_i  (lane_status_i),
        .gbe_rst_i      (gbe_rst_o),
        .lane_ctrl_i    (lane_ctrl_o),
        .error_count_o  (error_count),
        .pending_o      (pending),
        .timeout_o      (timeout)
    );

    always #10 wb_clk_i = ~wb_clk_i;

    // lane ready, random while stalls are enabled
    always @(posedge wb_clk_i) begin
        logic [31:0] rnd;
        rnd = $random(seed);
        #2;
        m_hdr_ready_i  = stall_en ? rnd[5:0] : '1;
        m_beat_ready_i = stall_en ? rnd[13:8] : '1;
    end

    // DRP target answers two cycles after the strobe
    always @(posedge wb_clk_i) begin
        logic [1:0] wait_n;
        wb_rsp_t    rsp_n;
        rsp_n  = '0;
        wait_n = 2'd0;
        if (rst_n_i && drp_req_o.cyc && !drp_rsp_i.ack) begin
            if (drp_wait == 2'd1) begin
                rsp_n.ack = 1'b1;
                rsp_n.dat = {drp_req_o.adr, ~drp_req_o.adr, 6'b101101};
                wait_n    = drp_wait;
            end else begin
                wait_n = drp_wait + 2'd1;
            end
        end
        #2;
        drp_wait  = wait_n;
        drp_rsp_i = rsp_n;
    end

    task automatic send_packet(input logic [15:0] port, input int nbeats);
        logic [31:0] rnd;
        rnd = $random(seed);
        @(posedge wb_clk_i);
        #2;
        s_hdr_i       = '{dest_port: port, src_port: rnd[15:0], src_addr: $random(seed)};
        s_hdr_valid_i = 1'b1;
        @(negedge wb_clk_i);
        while (!s_hdr_ready_o) @(negedge wb_clk_i);
        @(posedge wb_clk_i);
        #2;
        s_hdr_valid_i = 1'b0;
        for (int b = 0; b < nbeats; b++) begin
            s_beat_i.data  = {$random(seed), $random(seed)};
            s_beat_i.keep  = (b == nbeats - 1) ? 8'h0f : 8'hff;
            s_beat_i.last  = (b == nbeats - 1);
            s_beat_valid_i = 1'b1;
            @(negedge wb_clk_i);
            while (!s_beat_ready_o) @(negedge wb_clk_i);
            @(posedge wb_clk_i);
            #2;
        end
        s_beat_valid_i = 1'b0;
    endtask

    task automatic wb_access(input logic we, input logic [13:0] adr, input logic [3:0] sel,
                             input logic [31:0] dat);
        @(posedge wb_clk_i);
        #2;
        gtp_req_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
        @(negedge wb_clk_i);
        while (!gtp_rsp_o.ack) @(negedge wb_clk_i);
        @(posedge wb_clk_i);
        #2;
        gtp_req_i = '0;
    endtask

    initial begin
        logic [15:0] ports [8];
        logic [31:0] rnd;
        ports = '{16'd21614, 16'd21603, 16'd21601, 16'd21608,
                  16'd37, 16'd21617, 16'd80, 16'd21622};
        wb_clk_i       = 1'b0;
        rst_n_i        = 1'b0;
        s_hdr_i        = '0;
        s_hdr_valid_i  = 1'b0;
        s_beat_i       = '0;
        s_beat_valid_i = 1'b0;
        m_hdr_ready_i  = '1;
        m_beat_ready_i = '1;
        gtp_req_i      = '0;
        drp_rsp_i      = '0;
        drp_wait       = 2'd0;
        qpll_lock_i    = 1'b1;
        lane_status_i  = '0;
        stall_en       = 1'b0;
        test_name      = "reset";
        repeat (3) @(posedge wb_clk_i);
        #2;
        rst_n_i = 1'b1;

        test_name = "service_lanes";
        send_packet(16'd21614, 3);
        send_packet(16'd21603, 3);
        send_packet(16'd21601, 2);
        send_packet(16'd21608, 4);
        send_packet(16'd37, 1);

        test_name = "masked_lane0";
        send_packet(16'd21616, 2);
        send_packet(16'd21618, 2);
        send_packet(16'd21623, 2);
        send_packet(16'd21624, 2);

        test_name = "unmatched_drop";
        send_packet(16'd80, 3);

        test_name = "ready_stalls";
        stall_en = 1'b1;
        for (int p = 0; p < 8; p++) begin
            rnd = $random(seed);
            send_packet(ports[rnd[2:0]], 6);
        end
        stall_en = 1'b0;

        test_name = "local_regs";
        lane_status_i[0] = '{block_lock: 1'b1, high_ber: 1'b0, dmonitor: 16'h3a5c};
        lane_status_i[1] = '{block_lock: 1'b0, high_ber: 1'b1, dmonitor: 16'hc0de};
        wb_access(1'b1, 14'h0000, 4'b0001, 32'h0000_0011);
        wb_access(1'b1, 14'h0004, 4'b0010, 32'h0000_0500);
        wb_access(1'b0, 14'h0000, 4'b1111, 32'h0);
        wb_access(1'b0, 14'h0004, 4'b1111, 32'h0);
        qpll_lock_i = 1'b0;
        wb_access(1'b1, 14'h0004, 4'b0011, 32'h0000_0310);
        wb_access(1'b1, 14'h0000, 4'b0010, 32'h0000_0201);
        wb_access(1'b0, 14'h0004, 4'b1111, 32'h0);
        wb_access(1'b0, 14'h0000, 4'b1111, 32'h0);

        test_name = "drp_window";
        wb_access(1'b0, 14'h2010, 4'b1111, 32'h0);
        wb_access(1'b1, 14'h3abc, 4'b0110, 32'hdead_beef);
        wb_access(1'b0, 14'h2004, 4'b1111, 32'h0);

        repeat (5) @(posedge wb_clk_i);
        $display("checks done: %0d errors, %0d transfers undelivered", error_count, pending);
        if (error_count == 0 && pending == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    always @(posedge wb_clk_i) begin
        if (timeout) begin
            $display("run stopped: cycle limit reached with %0d errors", error_count);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

// File: list.f
+incdir+common
common/udp_stream_pkg.sv
common/gbe_ctrl_pkg.sv
port_switch/udp_port_classifier.sv
port_switch/udp_port_switch.sv
gbe_regs/gbe_lane_regs.sv
rtl/udp_hub_top.sv
verif/udp_hub_checker.sv
verif/tb_udp_hub.sv

// File: run_sim.sh
#!/bin/sh
# build and run the UDP hub testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_udp_hub -f list.f -o sim_udp_hub
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_udp_hub > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
